// ==== icache_top.f ====
verilog/icache_pkg.sv
verilog/icache_ctrl.sv
verilog/icache_tag_array.sv
verilog/icache_data_array.sv
verilog/icache_refill.sv
verilog/icache_top.sv
sim/icache_mem_model.sv
sim/icache_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile the icache testbench with verilator, run it, and look for the pass line

cd "$(dirname "$0")"
LOG=sim.log

verilator --binary --timing --assert -j 0 \
	--top-module icache_tb \
	-f icache_top.f \
	--Mdir obj_dir -o icache_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/icache_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi

if grep -q '^\*\*\* PASSED \*\*\*$' "$LOG"; then
	exit 0
else
	echo "pass line not found in $LOG"
	exit 1
fi

// ==== sim/icache_mem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_mem_model #(
	parameter int CREDITS = 2
) (
	input  wire                       clk,
	input  wire                       rst,
	input  wire                       slow,
	input  wire                       req_valid,
	input  wire icache_pkg::mem_req_t req,
	output logic                      credit,
	output logic                      beat_valid,
	output icache_pkg::mem_beat_t     beat,
	output logic [31:0]               beat_addr,
	input  wire [31:0]                beat_data,
	output logic                      overrun
);

	// line requests waiting for service, at most CREDITS deep
	icache_pkg::mem_req_t pending [$];
	icache_pkg::mem_req_t cur;
	// cycle numbers at which held credits go back
	int credit_due [$];
	logic busy;
	logic last_q;
	int wait_cycles;
	int beat_n;
	int cycle;
	// requests taken and not yet credited
	int held;

	// contents come from the testbench formula on the beat address
	assign beat.data = beat_data;
	assign beat.last = last_q;

	initial begin
		credit = 1'b0;
		beat_valid = 1'b0;
		beat_addr = '0;
		overrun = 1'b0;
		last_q = 1'b0;
		busy = 1'b0;
		wait_cycles = 0;
		beat_n = 0;
		cycle = 0;
		held = 0;
		forever begin
			// requests sampled mid-cycle
			@(negedge clk);
			if (rst) begin
				pending.delete();
				credit_due.delete();
				busy = 1'b0;
				held = 0;
			end else if (req_valid) begin
				// more requests than queue slots
				if (held >= CREDITS)
					overrun = 1'b1;
				held++;
				pending.push_back(req);
			end
			// outputs move just after the edge
			@(posedge clk);
			#1;
			cycle++;
			credit = 1'b0;
			beat_valid = 1'b0;
			last_q = 1'b0;
			if (busy) begin
				if (wait_cycles > 0) begin
					wait_cycles--;
				end else begin
					// word 0 first, last on the fourth
					beat_valid = 1'b1;
					beat_addr = {cur.line_addr, 2'(beat_n), 2'b00};
					last_q = (beat_n == 3);
					if (beat_n == 3) begin
						// queue slot frees with the last beat, much later when slow
						credit_due.push_back(cycle + (slow ? 40 : 0));
						busy = 1'b0;
					end
					beat_n++;
				end
			end else if (pending.size() != 0) begin
				cur = pending.pop_front();
				busy = 1'b1;
				beat_n = 0;
				wait_cycles = int'($urandom_range(4, 1)) + (slow ? 8 : 0);
			end
			if (credit_due.size() != 0 && credit_due[0] <= cycle) begin
				credit = 1'b1;
				void'(credit_due.pop_front());
				held--;
			end
		end
	end

endmodule

`default_nettype wire

// ==== sim/icache_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_tb;

	localparam int SETS = 64;
	localparam int MEM_CREDITS = 2;
	localparam int TIMEOUT = 200;
	// lines this far apart share a set
	localparam logic [31:0] SET_STRIDE = 32'(SETS * 16);
	// test lines, each in a set of its own
	localparam logic [31:0] LINE_A = 32'h0000_1000;
	localparam logic [31:0] LINE_B = 32'h0002_0040;
	localparam logic [31:0] LINE_C = 32'h0003_0080;
	localparam logic [31:0] LINE_D = 32'h0004_00c0;

	logic clk;
	logic rst;
	logic flush;
	logic req_valid;
	icache_pkg::fetch_req_t req;
	logic req_ready;
	logic resp_valid;
	icache_pkg::fetch_resp_t resp;
	logic resp_ready;
	logic mem_req_valid;
	icache_pkg::mem_req_t mem_req;
	logic mem_credit;
	logic mem_beat_valid;
	icache_pkg::mem_beat_t mem_beat;
	logic slow;
	logic [31:0] beat_addr;
	logic [31:0] beat_data;
	logic overrun;
	// line of the last fetch driven, the only one that may miss
	logic [27:0] miss_line;

	int errors;
	int tests_run;
	int tests_failed;
	// memory side monitor
	int mem_reqs;
	int credit_count;
	int min_credits;
	int monitor_errors;

	// instruction stored at a byte address, mixes the whole word address
	function automatic logic [31:0] word_at(input logic [31:0] addr);
		logic [31:0] a;
		a = {addr[31:2], 2'b00};
		return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]} ^ 32'h0bad_c0de;
	endfunction

	assign beat_data = word_at(beat_addr);

	icache_top #(.SETS(SETS), .MEM_CREDITS(MEM_CREDITS)) uut (
		.clk, .rst, .flush,
		.req_valid, .req, .req_ready,
		.resp_valid, .resp, .resp_ready,
		.mem_req_valid, .mem_req, .mem_credit,
		.mem_beat_valid, .mem_beat
	);

	icache_mem_model #(.CREDITS(MEM_CREDITS)) u_mem (
		.clk, .rst, .slow,
		.req_valid(mem_req_valid), .req(mem_req), .credit(mem_credit),
		.beat_valid(mem_beat_valid), .beat(mem_beat),
		.beat_addr, .beat_data, .overrun
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// credit count rebuilt from the wires, checked mid-cycle
	always @(negedge clk) begin
		if (rst) begin
			credit_count = MEM_CREDITS;
			min_credits = MEM_CREDITS;
			mem_reqs = 0;
			monitor_errors = 0;
		end else begin
			if (mem_req_valid) begin
				assert (credit_count > 0) else begin
					$display("Error %0t: mem_req_valid with no credit left", $time);
					monitor_errors++;
				end
				assert (mem_req.line_addr == miss_line) else begin
					$display("Error %0t: mem_req line is %0h, expected %0h",
						$time, mem_req.line_addr, miss_line);
					monitor_errors++;
				end
				credit_count--;
				mem_reqs++;
			end
			if (mem_credit)
				credit_count++;
			if (credit_count < min_credits)
				min_credits = credit_count;
			assert (credit_count <= MEM_CREDITS) else begin
				$display("Error %0t: more credits returned than issued", $time);
				monitor_errors++;
			end
			assert (!overrun) else begin
				$display("memory got more requests than it has queue slots");
				monitor_errors++;
			end
		end
	end

	function automatic int total_errors();
		return errors + monitor_errors;
	endfunction

	task automatic expect_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
		assert (got == exp) else begin
			$display("Error %0t: %s is %0h, expected %0h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic note_timeout(input string what);
		$display("timed out after %0d cycles waiting for %s", TIMEOUT, what);
		errors++;
	endtask

	task automatic finish_test(input string name, input int start_errors);
		tests_run++;
		if (total_errors() != start_errors) begin
			tests_failed++;
			$display("test %s: failed", name);
		end else begin
			$display("test %s: ok", name);
		end
	endtask

	task automatic drive_req(input logic [31:0] addr);
		req_valid = 1'b1;
		req.addr = addr;
		miss_line = addr[31:4];
	endtask

	// returns just after the accepting edge with req_valid dropped
	task automatic wait_accept(output bit ok);
		int n;
		ok = 1'b0;
		for (n = 0; n < TIMEOUT && !ok; n++) begin
			@(negedge clk);
			if (req_ready)
				ok = 1'b1;
		end
		if (!ok)
			note_timeout("req_ready");
		@(posedge clk);
		#1;
		req_valid = 1'b0;
	endtask

	// lat counts edges from acceptance to resp_valid, ends mid-cycle
	task automatic wait_resp(output int lat, output bit ok);
		lat = 0;
		ok = 1'b0;
		while (!ok && lat < TIMEOUT) begin
			@(posedge clk);
			lat++;
			@(negedge clk);
			if (resp_valid)
				ok = 1'b1;
		end
		if (!ok)
			note_timeout("resp_valid");
	endtask

	// one fetch start to finish, hit or miss decided by memory traffic
	task automatic fetch(input logic [31:0] addr, input bit expect_miss);
		int reqs_before;
		int lat;
		bit ok;
		reqs_before = mem_reqs;
		drive_req(addr);
		wait_accept(ok);
		wait_resp(lat, ok);
		if (ok) begin
			expect_eq(resp.inst, word_at(addr), "inst");
			expect_eq(32'(resp.word), 32'(addr[3:2]), "word offset");
			if (!expect_miss)
				expect_eq(lat, 1, "hit latency");
		end
		@(posedge clk);
		#1;
		expect_eq(mem_reqs - reqs_before, expect_miss ? 1 : 0, "memory requests");
	endtask

	task automatic test_cold_miss();
		int start;
		start = total_errors();
		fetch(LINE_A + 32'h4, 1'b1);
		finish_test("cold miss", start);
	endtask

	task automatic test_hits();
		int start;
		int reqs_before;
		int sent;
		int done;
		int n;
		start = total_errors();
		fetch(LINE_A, 1'b0);
		fetch(LINE_A + 32'h8, 1'b0);
		fetch(LINE_A + 32'hc, 1'b0);
		// stream of five hits with req_valid held high
		reqs_before = mem_reqs;
		sent = 0;
		done = 0;
		drive_req(LINE_A);
		for (n = 0; n < TIMEOUT && done < 5; n++) begin
			@(negedge clk);
			if (resp_valid) begin
				expect_eq(resp.inst, word_at(LINE_A + 32'((done % 4) * 4)), "streamed inst");
				// the next fetch goes in on the edge this response leaves
				if (sent < 5)
					expect_eq(32'(req_ready), 32'd1, "req_ready beside response");
				done++;
			end
			if (req_valid && req_ready)
				sent++;
			@(posedge clk);
			#1;
			if (sent < 5)
				req.addr = LINE_A + 32'((sent % 4) * 4);
			else
				req_valid = 1'b0;
		end
		if (done < 5)
			note_timeout("streamed responses");
		expect_eq(mem_reqs - reqs_before, 0, "memory requests in stream");
		finish_test("hits and word select", start);
	endtask

	task automatic test_round_robin();
		int start;
		int n;
		start = total_errors();
		// five tags into one set, the fifth fill reuses the first way
		for (n = 0; n < 5; n++)
			fetch(LINE_B + 32'(n) * SET_STRIDE, 1'b1);
		fetch(LINE_B + SET_STRIDE + 32'h4, 1'b0);
		fetch(LINE_B, 1'b1);
		finish_test("round robin", start);
	endtask

	task automatic test_back_pressure();
		int start;
		int lat;
		int n;
		bit ok;
		logic [31:0] held;
		start = total_errors();
		resp_ready = 1'b0;
		drive_req(LINE_A + 32'h4);
		wait_accept(ok);
		wait_resp(lat, ok);
		held = resp.inst;
		expect_eq(held, word_at(LINE_A + 32'h4), "held inst");
		// a second fetch waits while decode stalls
		for (n = 0; n < 6; n++) begin
			@(posedge clk);
			#1;
			drive_req(LINE_A + 32'h8);
			@(negedge clk);
			expect_eq(32'(resp_valid), 32'd1, "resp_valid under back-pressure");
			expect_eq(resp.inst, held, "inst under back-pressure");
			expect_eq(32'(req_ready), 32'd0, "req_ready under back-pressure");
		end
		@(posedge clk);
		#1;
		resp_ready = 1'b1;
		@(negedge clk);
		expect_eq(32'(req_ready), 32'd1, "req_ready on completion");
		@(posedge clk);
		#1;
		req_valid = 1'b0;
		wait_resp(lat, ok);
		if (ok)
			expect_eq(resp.inst, word_at(LINE_A + 32'h8), "inst after back-pressure");
		@(posedge clk);
		#1;
		finish_test("back-pressure", start);
	endtask

	task automatic test_flush();
		int start;
		int reqs_before;
		int n;
		bit ok;
		start = total_errors();
		reqs_before = mem_reqs;
		drive_req(LINE_C + 32'h8);
		wait_accept(ok);
		// kill during the lookup of a miss
		flush = 1'b1;
		@(posedge clk);
		#1;
		flush = 1'b0;
		// refill finishes silently, req_ready comes back in idle
		ok = 1'b0;
		for (n = 0; n < TIMEOUT && !ok; n++) begin
			@(negedge clk);
			expect_eq(32'(resp_valid), 32'd0, "resp_valid after flush");
			if (req_ready)
				ok = 1'b1;
		end
		if (!ok)
			note_timeout("idle after flush");
		expect_eq(mem_reqs - reqs_before, 1, "memory requests of flushed miss");
		@(posedge clk);
		#1;
		fetch(LINE_C + 32'h8, 1'b0);
		finish_test("flush", start);
	endtask

	task automatic test_credits();
		int start;
		int n;
		bit ok;
		start = total_errors();
		min_credits = MEM_CREDITS;
		// slow memory holds its credits back, so the third miss has to wait
		slow = 1'b1;
		for (n = 0; n < 3; n++)
			fetch(LINE_D + 32'(n * 16 + 4), 1'b1);
		slow = 1'b0;
		expect_eq(min_credits, 0, "lowest credit count");
		ok = 1'b0;
		for (n = 0; n < TIMEOUT && !ok; n++) begin
			@(negedge clk);
			if (credit_count == MEM_CREDITS)
				ok = 1'b1;
		end
		if (!ok)
			note_timeout("credit return");
		@(posedge clk);
		#1;
		finish_test("credit limit", start);
	endtask

	initial begin
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		rst = 1'b1;
		flush = 1'b0;
		req_valid = 1'b0;
		req = '0;
		miss_line = '0;
		resp_ready = 1'b1;
		slow = 1'b0;
		void'($urandom(32'h296e));
		repeat (5) @(posedge clk);
		#1;
		rst = 1'b0;
		// first cycle out of reset stays closed
		@(negedge clk);
		expect_eq(32'(req_ready), 32'd0, "req_ready after reset");
		expect_eq(32'(resp_valid), 32'd0, "resp_valid after reset");
		expect_eq(32'(mem_req_valid), 32'd0, "mem_req_valid after reset");
		@(posedge clk);
		#1;
		test_cold_miss();
		test_hits();
		test_round_robin();
		test_back_pressure();
		test_flush();
		test_credits();
		$display("tests run %0d, failed %0d, errors %0d",
			tests_run, tests_failed, total_errors());
		if (tests_failed == 0 && total_errors() == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog/icache_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_ctrl #(
	parameter int SETS = 64
) (
	input  wire                          clk,
	input  wire                          rst,
	input  wire                          flush,
	input  wire                          req_valid,
	input  wire icache_pkg::fetch_req_t  req,
	output logic                         req_ready,
	output logic                         resp_valid,
	output icache_pkg::fetch_resp_t      resp,
	input  wire                          resp_ready,
	input  wire icache_pkg::way_onehot_t hit,
	output logic                         lookup,
	output logic                         fill,
	output logic                         rd_en,
	output logic                         wr_en,
	output icache_pkg::way_onehot_t      way_sel,
	input  wire icache_pkg::way_onehot_t victim,
	output logic                         refill_start,
	input  wire                          line_done,
	input  wire icache_pkg::line_t       rdata,
	output logic [$clog2(SETS)-1:0]      index,
	output icache_pkg::fetch_req_t       lookup_addr
);

	localparam int IDX_W = $clog2(SETS);

	icache_pkg::cache_state_e state;
	icache_pkg::cache_state_e state_next;
	logic init_done;
	logic killed;
	logic any_hit;
	logic accept;
	logic [icache_pkg::WORD_SEL_W-1:0] word_sel;

	assign any_hit = |hit;

	// open in idle, or in respond on the cycle the response leaves
	// a flush cycle never takes a new fetch
	assign req_ready = init_done && !flush &&
		((state == icache_pkg::IDLE) ||
		 (state == icache_pkg::RESPOND && resp_ready));
	assign accept = req_valid && req_ready;

	// strobes toward the arrays and the refill path
	assign lookup = (state == icache_pkg::LOOKUP);
	assign fill = (state == icache_pkg::FILL);
	assign rd_en = lookup && any_hit;
	assign wr_en = fill;
	assign refill_start = (state == icache_pkg::MISS_REQ);
	// hit way on a read, victim way on a fill
	assign way_sel = fill ? victim : hit;

	assign index = lookup_addr.addr[icache_pkg::OFFSET_W +: IDX_W];

	// response is the registered line picked by the registered word offset
	assign word_sel = lookup_addr.addr[2 +: icache_pkg::WORD_SEL_W];
	assign resp_valid = (state == icache_pkg::RESPOND);
	assign resp.word = word_sel;
	assign resp.inst = rdata[word_sel];

	always_comb begin
		state_next = state;
		case (state)
			icache_pkg::IDLE: begin
				if (accept)
					state_next = icache_pkg::LOOKUP;
			end
			icache_pkg::LOOKUP: begin
				// a miss keeps going under flush so the line still lands
				if (!any_hit)
					state_next = icache_pkg::MISS_REQ;
				else if (flush)
					state_next = icache_pkg::IDLE;
				else
					state_next = icache_pkg::RESPOND;
			end
			icache_pkg::MISS_REQ: state_next = icache_pkg::REFILL;
			icache_pkg::REFILL: begin
				if (line_done)
					state_next = icache_pkg::FILL;
			end
			icache_pkg::FILL: begin
				// killed miss ends silently after the write
				if (killed || flush)
					state_next = icache_pkg::IDLE;
				else
					state_next = icache_pkg::RESPOND;
			end
			icache_pkg::RESPOND: begin
				if (flush)
					state_next = icache_pkg::IDLE;
				else if (accept)
					state_next = icache_pkg::LOOKUP;
				else if (resp_ready)
					state_next = icache_pkg::IDLE;
			end
			default: state_next = icache_pkg::IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= icache_pkg::IDLE;
			init_done <= 1'b0;
			killed <= 1'b0;
		end else begin
			state <= state_next;
			init_done <= 1'b1;
			// remember a flush that hit while the miss was in flight
			if (accept)
				killed <= 1'b0;
			else if (fill)
				killed <= 1'b0;
			else if (flush && (lookup || refill_start || state == icache_pkg::REFILL))
				killed <= 1'b1;
		end
	end

	// accepted fetch address, also the miss address during refill
	always_ff @(posedge clk) begin
		if (accept)
			lookup_addr <= req;
	end

	// decode must see the same word until it takes it
	a_resp_hold: assert property (@(posedge clk) disable iff (rst)
		resp_valid && !resp_ready && !flush |=> resp_valid && $stable(resp));

endmodule

`default_nettype wire

// ==== verilog/icache_data_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_data_array #(
	parameter int SETS = 64
) (
	input  wire                          clk,
	input  wire                          rd_en,
	input  wire                          wr_en,
	input  wire icache_pkg::way_onehot_t way_sel,
	input  wire [$clog2(SETS)-1:0]       index,
	input  wire icache_pkg::line_t       wdata,
	output icache_pkg::line_t            rdata
);

	// one line memory per way
	icache_pkg::line_t mem [icache_pkg::NUM_WAYS][SETS];
	icache_pkg::line_t sel_line;

	// write the selected way only
	always_ff @(posedge clk) begin
		if (wr_en) begin
			for (int w = 0; w < icache_pkg::NUM_WAYS; w++)
				if (way_sel[w])
					mem[w][index] <= wdata;
		end
	end

	// way_sel is one-hot, so an or of the masked ways is the mux
	always_comb begin
		sel_line = '0;
		for (int w = 0; w < icache_pkg::NUM_WAYS; w++)
			if (way_sel[w])
				sel_line = sel_line | mem[w][index];
	end

	// output register
	// a fill also lands here so the missed word is ready next cycle
	always_ff @(posedge clk) begin
		if (wr_en)
			rdata <= wdata;
		else if (rd_en)
			rdata <= sel_line;
	end

endmodule

`default_nettype wire

// ==== verilog/icache_pkg.sv ====
`default_nettype none

package icache_pkg;

	// fetch addresses are byte addresses of 32-bit instructions
	localparam int ADDR_W = 32;
	localparam int INST_W = 32;

	// line format is fixed
	// four beats per refill and a 4-bit victim rotation depend on it
	localparam int LINE_BYTES = 16;
	localparam int WORDS_PER_LINE = 4;
	localparam int NUM_WAYS = 4;

	// derived address fields
	localparam int OFFSET_W = $clog2(LINE_BYTES);
	localparam int WORD_SEL_W = $clog2(WORDS_PER_LINE);
	localparam int LINE_ADDR_W = ADDR_W - OFFSET_W;

	// request from the fetch stage
	typedef struct packed {
		logic [ADDR_W-1:0] addr;
	} fetch_req_t;

	// answer to decode, word tells which slot of the line it came from
	typedef struct packed {
		logic [INST_W-1:0]     inst;
		logic [WORD_SEL_W-1:0] word;
	} fetch_resp_t;

	// line fetch toward the backing memory
	typedef struct packed {
		logic [LINE_ADDR_W-1:0] line_addr;
	} mem_req_t;

	// one returned word, last marks the fourth beat
	typedef struct packed {
		logic [INST_W-1:0] data;
		logic              last;
	} mem_beat_t;

	// word 0 sits in the low slot
	typedef logic [WORDS_PER_LINE-1:0][INST_W-1:0] line_t;

	// one bit per way, for hit vectors and the victim pointer
	typedef logic [NUM_WAYS-1:0] way_onehot_t;

	typedef enum logic [2:0] {
		IDLE,
		LOOKUP,
		MISS_REQ,
		REFILL,
		FILL,
		RESPOND
	} cache_state_e;

endpackage

`default_nettype wire

// ==== verilog/icache_refill.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_refill #(
	parameter int MEM_CREDITS = 2
) (
	input  wire                         clk,
	input  wire                         rst,
	input  wire                         refill_start,
	input  wire icache_pkg::fetch_req_t miss_addr,
	output logic                        mem_req_valid,
	output icache_pkg::mem_req_t        mem_req,
	input  wire                         mem_credit,
	input  wire                         mem_beat_valid,
	input  wire icache_pkg::mem_beat_t  mem_beat,
	output icache_pkg::line_t           line,
	output logic                        line_done
);

	localparam int CRED_W = $clog2(MEM_CREDITS + 1);

	logic [CRED_W-1:0] credits;
	logic pending;
	logic issue;

	// request waits here until the memory has a free slot
	assign issue = pending && (credits != '0);
	assign mem_req_valid = issue;

	// one credit spent per request, one back per memory pulse
	always_ff @(posedge clk) begin
		if (rst)
			credits <= CRED_W'(MEM_CREDITS);
		else
			credits <= credits - CRED_W'(issue) + CRED_W'(mem_credit);
	end

	always_ff @(posedge clk) begin
		if (rst)
			pending <= 1'b0;
		else if (refill_start)
			pending <= 1'b1;
		else if (issue)
			pending <= 1'b0;
	end

	// line address held with the pending request
	always_ff @(posedge clk) begin
		if (refill_start)
			mem_req.line_addr <= miss_addr.addr[icache_pkg::ADDR_W-1:icache_pkg::OFFSET_W];
	end

	// beats shift in from the top, word 0 ends up in the low slot
	always_ff @(posedge clk) begin
		if (mem_beat_valid)
			line <= {mem_beat.data, line[icache_pkg::WORDS_PER_LINE-1:1]};
	end

	// done one cycle after the last beat, when the line is complete
	always_ff @(posedge clk) begin
		if (rst)
			line_done <= 1'b0;
		else
			line_done <= mem_beat_valid && mem_beat.last;
	end

	// memory must not return more credits than it was given
	a_credit_max: assert property (@(posedge clk) disable iff (rst)
		credits <= CRED_W'(MEM_CREDITS));

	// an empty counter only refills from a returned credit
	a_credit_min: assert property (@(posedge clk) disable iff (rst)
		credits == '0 && !mem_credit |=> credits == '0);

endmodule

`default_nettype wire

// ==== verilog/icache_tag_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_tag_array #(
	parameter int SETS = 64
) (
	input  wire                         clk,
	input  wire                         rst,
	input  wire icache_pkg::fetch_req_t lookup_addr,
	input  wire                         lookup,
	input  wire                         fill,
	output icache_pkg::way_onehot_t     hit,
	output icache_pkg::way_onehot_t     victim
);

	localparam int IDX_W = $clog2(SETS);
	localparam int TAG_W = icache_pkg::ADDR_W - icache_pkg::OFFSET_W - IDX_W;

	logic [IDX_W-1:0] index;
	logic [TAG_W-1:0] tag;
	// valid bits per way, one per set
	logic [SETS-1:0] valid_q [icache_pkg::NUM_WAYS];
	logic [TAG_W-1:0] tag_q [icache_pkg::NUM_WAYS][SETS];
	icache_pkg::way_onehot_t way_match;

	// address split
	assign index = lookup_addr.addr[icache_pkg::OFFSET_W +: IDX_W];
	assign tag = lookup_addr.addr[icache_pkg::ADDR_W-1 -: TAG_W];

	// all four ways compared at once
	always_comb begin
		for (int w = 0; w < icache_pkg::NUM_WAYS; w++)
			way_match[w] = valid_q[w][index] && (tag_q[w][index] == tag);
	end

	// hit only reported while the control is looking up
	assign hit = lookup ? way_match : '0;

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int w = 0; w < icache_pkg::NUM_WAYS; w++)
				valid_q[w] <= '0;
		end else if (fill) begin
			for (int w = 0; w < icache_pkg::NUM_WAYS; w++)
				if (victim[w])
					valid_q[w][index] <= 1'b1;
		end
	end

	// tag of the miss goes into the victim way
	always_ff @(posedge clk) begin
		if (fill) begin
			for (int w = 0; w < icache_pkg::NUM_WAYS; w++)
				if (victim[w])
					tag_q[w][index] <= tag;
		end
	end

	// round-robin pointer shared by all sets, steps once per fill
	always_ff @(posedge clk) begin
		if (rst)
			victim <= icache_pkg::way_onehot_t'(1);
		else if (fill)
			victim <= {victim[icache_pkg::NUM_WAYS-2:0], victim[icache_pkg::NUM_WAYS-1]};
	end

	// fills only follow a miss, so a set never holds one tag twice
	a_hit_onehot: assert property (@(posedge clk) disable iff (rst)
		$onehot0(hit));

endmodule

`default_nettype wire

// ==== verilog/icache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_top #(
	parameter int SETS        = 64,
	parameter int MEM_CREDITS = 2
) (
	input  wire                         clk,
	input  wire                         rst,
	input  wire                         flush,
	input  wire                         req_valid,
	input  wire icache_pkg::fetch_req_t req,
	output logic                        req_ready,
	output logic                        resp_valid,
	output icache_pkg::fetch_resp_t     resp,
	input  wire                         resp_ready,
	output logic                        mem_req_valid,
	output icache_pkg::mem_req_t        mem_req,
	input  wire                         mem_credit,
	input  wire                         mem_beat_valid,
	input  wire icache_pkg::mem_beat_t  mem_beat
);

	// control to arrays
	logic lookup;
	logic fill;
	logic rd_en;
	logic wr_en;
	icache_pkg::way_onehot_t way_sel;
	logic [$clog2(SETS)-1:0] index;
	icache_pkg::fetch_req_t lookup_addr;
	// arrays back to control
	icache_pkg::way_onehot_t hit;
	icache_pkg::way_onehot_t victim;
	icache_pkg::line_t rdata;
	// refill path
	logic refill_start;
	logic line_done;
	icache_pkg::line_t line;

	icache_ctrl #(.SETS(SETS)) u_ctrl (
		.clk, .rst, .flush,
		.req_valid, .req, .req_ready,
		.resp_valid, .resp, .resp_ready,
		.hit, .lookup, .fill, .rd_en, .wr_en, .way_sel, .victim,
		.refill_start, .line_done, .rdata, .index, .lookup_addr
	);

	icache_tag_array #(.SETS(SETS)) u_tag (
		.clk, .rst, .lookup_addr, .lookup, .fill, .hit, .victim
	);

	// refill line feeds the write port directly
	icache_data_array #(.SETS(SETS)) u_data (
		.clk, .rd_en, .wr_en, .way_sel, .index, .wdata(line), .rdata
	);

	icache_refill #(.MEM_CREDITS(MEM_CREDITS)) u_refill (
		.clk, .rst, .refill_start, .miss_addr(lookup_addr),
		.mem_req_valid, .mem_req, .mem_credit,
		.mem_beat_valid, .mem_beat, .line, .line_done
	);

endmodule

`default_nettype wire
